/* cpu_io_pkg.sv */
`default_nettype none

// ------------------------------
// CPU side I/O port definitions
// ------------------------------
package cpu_io_pkg;

	// One access on the CPU bus, sampled on every rising edge
	typedef struct packed {
		logic		ioreq;		// I/O space select
		logic		valid;		// Access strobe
		logic		write;		// 1 for write, 0 for read
		logic [7:0]	address;	// Port number
		logic [7:0]	wdata;		// Byte to write
	} cpu_bus_t;

	// ------------------------------
	// Register map
	// ------------------------------
	// Data bytes 0 to 15 sit at 8'h20 to 8'h2F
	localparam logic [7:0] REG_DATA_BASE	= 8'h20;

	// Write side
	localparam logic [7:0] REG_MASK_LO		= 8'h30;	// Byte mask bits 7..0
	localparam logic [7:0] REG_MASK_HI		= 8'h31;	// Byte mask bits 15..8
	localparam logic [7:0] REG_ADDR0		= 8'h32;	// Column low bits
	localparam logic [7:0] REG_ADDR1		= 8'h33;
	localparam logic [7:0] REG_ADDR2		= 8'h34;
	localparam logic [7:0] REG_ADDR3		= 8'h35;	// Bank in bits 2..0
	localparam logic [7:0] REG_CMD_WRITE	= 8'h36;	// Fires a write request
	localparam logic [7:0] REG_CMD_READ		= 8'h37;	// Fires a read request

	// Read side, aliased onto the write ports
	localparam logic [7:0] REG_STATUS		= 8'h30;	// Init busy in bit 7, not ready in bit 0
	localparam logic [7:0] REG_BUSY_COUNT	= 8'h31;
	localparam logic [7:0] REG_DELAY_END	= 8'h32;
	localparam logic [7:0] REG_DELAY_COUNT	= 8'h33;

	// Busy counter stops here
	localparam logic [7:0] COUNT_MAX		= 8'hFF;

endpackage

`default_nettype wire

/* dram_if_pkg.sv */
`default_nettype none

// ------------------------------
// DDR3 controller port definitions
// ------------------------------
package dram_if_pkg;

	localparam int DRAM_ADDR_W	= 27;	// Bank 26..24, row 23..10, column 9..0
	localparam int DRAM_DATA_W	= 128;
	localparam int DRAM_MASK_W	= 16;	// One bit per data byte

	// Address fields
	localparam int BANK_LSB		= 24;
	localparam int BANK_W		= 3;
	localparam int ROW_LSB		= 10;
	localparam int ROW_W		= 14;

	localparam int NUM_BANKS	= 8;
	localparam int STORE_WORDS	= 16;	// Indexed by column bits 3..0
	localparam int STORE_IDX_W	= $clog2(STORE_WORDS);

	// Latencies in clock cycles
	localparam int INIT_CYCLES		= 64;
	localparam int ROW_HIT_CYCLES	= 4;
	localparam int ROW_MISS_CYCLES	= 12;
	localparam int TIMER_W			= $clog2(INIT_CYCLES + 1);

	typedef logic [TIMER_W-1:0] timer_t;

	// Request toward the controller
	typedef struct packed {
		logic [DRAM_ADDR_W-1:0]	address;
		logic					write;		// 1 for write, 0 for read
		logic [DRAM_DATA_W-1:0]	wdata;
		logic [DRAM_MASK_W-1:0]	wdata_mask;	// 1 keeps the byte, as DDR3 DM
	} dram_req_t;

	// Read data return
	typedef struct packed {
		logic [DRAM_DATA_W-1:0]	rdata;
		logic					rdata_en;	// One cycle pulse
	} dram_rsp_t;

	typedef enum logic [1:0] {
		T_INIT,		// Power up wait
		T_IDLE,		// Ready for a request
		T_ACCESS	// Latency countdown
	} timing_state_e;

endpackage

`default_nettype wire

/* test_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module test_controller (
	input  wire							clk,
	input  wire							reset_n,
	input  wire cpu_io_pkg::cpu_bus_t	bus,				// CPU port access
	output logic [7:0]					bus_rdata,
	output logic						bus_rdata_en,
	input  wire							sdram_init_busy,	// High during DRAM init
	output dram_if_pkg::dram_req_t		dram_req,
	output logic						dram_valid,
	input  wire							dram_ready,			// Low while controller is busy
	input  wire dram_if_pkg::dram_rsp_t	dram_rsp
);

	logic [7:0]							busy_count;		// Cycles with ready low
	logic [7:0]							delay_count;	// Cycles until read data
	logic								delay_end;
	logic [dram_if_pkg::DRAM_ADDR_W-1:0]	req_address;
	logic [dram_if_pkg::DRAM_DATA_W-1:0]	req_wdata;
	logic [dram_if_pkg::DRAM_MASK_W-1:0]	req_mask;
	logic								req_write;
	logic [dram_if_pkg::DRAM_DATA_W-1:0]	rd_word;		// Last word read back
	logic [7:0]							rd_byte;
	logic								rd_byte_en;
	logic								write_request;	// One cycle command pulses
	logic								read_request;
	logic								cpu_rd;
	logic								cpu_wr;
	logic								data_port;
	logic [3:0]							byte_sel;

	// ------------------------------
	// Bus decode
	// ------------------------------
	assign cpu_rd		= bus.ioreq && bus.valid && !bus.write;
	assign cpu_wr		= bus.ioreq && bus.valid && bus.write;
	assign data_port	= (bus.address[7:4] == cpu_io_pkg::REG_DATA_BASE[7:4]);
	assign byte_sel		= bus.address[3:0];

	// Read mux, data shows up one cycle after the access
	always_ff @(posedge clk) begin
		if (cpu_rd) begin
			if (data_port) begin
				rd_byte <= rd_word[byte_sel*8 +: 8];
			end else begin
				case (bus.address)
					cpu_io_pkg::REG_STATUS:			rd_byte <= {sdram_init_busy, 6'd0, ~dram_ready};
					cpu_io_pkg::REG_BUSY_COUNT:		rd_byte <= busy_count;
					cpu_io_pkg::REG_DELAY_END:		rd_byte <= {7'd0, delay_end};
					cpu_io_pkg::REG_DELAY_COUNT:	rd_byte <= delay_count;
					default:						rd_byte <= 8'h00;	// Unmapped port
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rd_byte_en <= 1'b0;
		end else begin
			rd_byte_en <= cpu_rd;
		end
	end

	assign bus_rdata	= rd_byte_en ? rd_byte : 8'h00;
	assign bus_rdata_en	= rd_byte_en;

	// ------------------------------
	// Request assembly
	// ------------------------------
	always_ff @(posedge clk) begin
		if (cpu_wr) begin
			if (data_port) begin
				req_wdata[byte_sel*8 +: 8] <= bus.wdata;
			end
			case (bus.address)
				cpu_io_pkg::REG_MASK_LO:	req_mask[7:0]			<= bus.wdata;
				cpu_io_pkg::REG_MASK_HI:	req_mask[15:8]			<= bus.wdata;
				cpu_io_pkg::REG_ADDR0:		req_address[7:0]		<= bus.wdata;
				cpu_io_pkg::REG_ADDR1:		req_address[15:8]		<= bus.wdata;
				cpu_io_pkg::REG_ADDR2:		req_address[23:16]		<= bus.wdata;
				cpu_io_pkg::REG_ADDR3:
					req_address[dram_if_pkg::DRAM_ADDR_W-1:dram_if_pkg::BANK_LSB] <=
						bus.wdata[dram_if_pkg::BANK_W-1:0];		// Bank bits only
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			write_request	<= 1'b0;
			read_request	<= 1'b0;
		end else begin
			write_request	<= cpu_wr && (bus.address == cpu_io_pkg::REG_CMD_WRITE);
			read_request	<= cpu_wr && (bus.address == cpu_io_pkg::REG_CMD_READ);
		end
	end

	// Valid holds until the controller takes it
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			dram_valid	<= 1'b0;
			req_write	<= 1'b0;
		end else if (write_request || read_request) begin
			dram_valid	<= 1'b1;
			req_write	<= write_request;
		end else if (dram_valid && dram_ready) begin
			dram_valid	<= 1'b0;	// Accepted
		end
	end

	assign dram_req = '{
		address:	req_address,
		write:		req_write,
		wdata:		req_wdata,
		wdata_mask:	req_mask
	};

	// ------------------------------
	// Read capture and counters
	// ------------------------------
	always_ff @(posedge clk) begin
		if (dram_rsp.rdata_en) begin
			rd_word <= dram_rsp.rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy_count <= 8'd0;
		end else if (write_request || read_request) begin
			busy_count <= 8'd0;
		end else if (!dram_ready && (busy_count != cpu_io_pkg::COUNT_MAX)) begin
			busy_count <= busy_count + 8'd1;	// Saturating
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			delay_count	<= 8'd0;
			delay_end	<= 1'b1;
		end else if (write_request || read_request) begin
			delay_count	<= 8'd0;
			delay_end	<= 1'b0;
		end else if (dram_rsp.rdata_en) begin
			delay_end	<= 1'b1;	// Freeze the count
		end else if (!delay_end) begin
			delay_count	<= delay_count + 8'd1;
		end
	end

endmodule

`default_nettype wire

/* dram_timing_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_timing_model (
	input  wire							clk,
	input  wire							reset_n,
	input  wire dram_if_pkg::dram_req_t	dram_req,
	input  wire							dram_valid,
	output logic						dram_ready,
	output logic						sdram_init_busy,
	output logic						store_write,	// Pulse after acceptance
	output logic						store_read,		// Pulse at completion
	output dram_if_pkg::dram_req_t		store_req		// Latched request
);

	dram_if_pkg::timing_state_e			state;
	dram_if_pkg::timer_t				timer;
	logic [dram_if_pkg::ROW_W-1:0]		open_row [dram_if_pkg::NUM_BANKS];
	logic [dram_if_pkg::NUM_BANKS-1:0]	row_valid;		// Bank has an open row
	logic [dram_if_pkg::BANK_W-1:0]		req_bank;
	logic [dram_if_pkg::ROW_W-1:0]		req_row;
	logic								row_hit;
	logic								accept;

	// ------------------------------
	// Address split and hit check
	// ------------------------------
	assign req_bank	= dram_req.address[dram_if_pkg::BANK_LSB +: dram_if_pkg::BANK_W];
	assign req_row	= dram_req.address[dram_if_pkg::ROW_LSB +: dram_if_pkg::ROW_W];
	assign row_hit	= row_valid[req_bank] && (open_row[req_bank] == req_row);

	assign dram_ready		= (state == dram_if_pkg::T_IDLE);
	assign sdram_init_busy	= (state == dram_if_pkg::T_INIT);
	assign accept			= dram_valid && dram_ready;

	// ------------------------------
	// Main FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state		<= dram_if_pkg::T_INIT;
			timer		<= dram_if_pkg::timer_t'(dram_if_pkg::INIT_CYCLES - 1);
			store_write	<= 1'b0;
			store_read	<= 1'b0;
		end else begin
			store_write	<= 1'b0;	// Strobes last one cycle
			store_read	<= 1'b0;
			unique case (state)
				dram_if_pkg::T_INIT: begin
					if (timer == '0) begin
						state <= dram_if_pkg::T_IDLE;
					end else begin
						timer <= timer - 1'b1;
					end
				end
				dram_if_pkg::T_IDLE: begin
					if (accept) begin
						state		<= dram_if_pkg::T_ACCESS;
						store_write	<= dram_req.write;
						// Ready stays low for the full latency
						timer <= row_hit ?
							dram_if_pkg::timer_t'(dram_if_pkg::ROW_HIT_CYCLES - 1) :
							dram_if_pkg::timer_t'(dram_if_pkg::ROW_MISS_CYCLES - 1);
					end
				end
				dram_if_pkg::T_ACCESS: begin
					if (timer == '0) begin
						state		<= dram_if_pkg::T_IDLE;
						store_read	<= !store_req.write;	// Reads return data now
					end else begin
						timer <= timer - 1'b1;
					end
				end
				default: state <= dram_if_pkg::T_INIT;
			endcase
		end
	end

	// ------------------------------
	// Open row tracking
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			row_valid <= '0;	// All banks precharged
		end else if (accept) begin
			row_valid[req_bank] <= 1'b1;
		end
	end

	// Miss opens the new row, hit rewrites the same value
	always_ff @(posedge clk) begin
		if (accept) begin
			open_row[req_bank]	<= req_row;
			store_req			<= dram_req;
		end
	end

endmodule

`default_nettype wire

/* dram_storage.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_storage (
	input  wire							clk,
	input  wire							reset_n,
	input  wire							store_write,
	input  wire							store_read,
	input  wire dram_if_pkg::dram_req_t	store_req,
	output dram_if_pkg::dram_rsp_t		dram_rsp
);

	logic [dram_if_pkg::DRAM_DATA_W-1:0]	mem [dram_if_pkg::STORE_WORDS];
	logic [dram_if_pkg::STORE_IDX_W-1:0]	word_idx;
	logic [dram_if_pkg::DRAM_DATA_W-1:0]	rd_word;
	logic									rd_en;

	// Low column bits pick the word
	assign word_idx = store_req.address[dram_if_pkg::STORE_IDX_W-1:0];

	// ------------------------------
	// Byte masked write
	// ------------------------------
	always_ff @(posedge clk) begin
		if (store_write) begin
			for (int i = 0; i < dram_if_pkg::DRAM_MASK_W; i++) begin
				if (!store_req.wdata_mask[i]) begin	// Mask bit 1 keeps old byte
					mem[word_idx][i*8 +: 8] <= store_req.wdata[i*8 +: 8];
				end
			end
		end
	end

	// ------------------------------
	// Read return
	// ------------------------------
	always_ff @(posedge clk) begin
		if (store_read) begin
			rd_word <= mem[word_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rd_en <= 1'b0;
		end else begin
			rd_en <= store_read;	// One cycle pulse with the word
		end
	end

	assign dram_rsp = '{
		rdata:		rd_word,
		rdata_en:	rd_en
	};

endmodule

`default_nettype wire

/* ddr3_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr3_test_top (
	input  wire							clk,
	input  wire							reset_n,
	input  wire cpu_io_pkg::cpu_bus_t	bus,
	output wire [7:0]					bus_rdata,
	output wire							bus_rdata_en,
	output wire							sdram_init_busy
);

	// Controller port
	dram_if_pkg::dram_req_t	dram_req;
	logic					dram_valid;
	logic					dram_ready;
	dram_if_pkg::dram_rsp_t	dram_rsp;

	// Model to store
	logic					store_write;
	logic					store_read;
	dram_if_pkg::dram_req_t	store_req;

	test_controller u_test_controller (
		.clk				(clk),
		.reset_n			(reset_n),
		.bus				(bus),
		.bus_rdata			(bus_rdata),
		.bus_rdata_en		(bus_rdata_en),
		.sdram_init_busy	(sdram_init_busy),
		.dram_req			(dram_req),
		.dram_valid			(dram_valid),
		.dram_ready			(dram_ready),
		.dram_rsp			(dram_rsp)
	);

	dram_timing_model u_dram_timing_model (
		.clk				(clk),
		.reset_n			(reset_n),
		.dram_req			(dram_req),
		.dram_valid			(dram_valid),
		.dram_ready			(dram_ready),
		.sdram_init_busy	(sdram_init_busy),
		.store_write		(store_write),
		.store_read			(store_read),
		.store_req			(store_req)
	);

	dram_storage u_dram_storage (
		.clk				(clk),
		.reset_n			(reset_n),
		.store_write		(store_write),
		.store_read			(store_read),
		.store_req			(store_req),
		.dram_rsp			(dram_rsp)
	);

endmodule

`default_nettype wire

/* tb_ddr3_test_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr3_test_checks (
	input  wire							clk,
	input  wire							reset_n,
	input  wire cpu_io_pkg::cpu_bus_t	bus,
	input  wire [7:0]					bus_rdata,
	input  wire							bus_rdata_en,
	input  wire dram_if_pkg::dram_req_t	dram_req,
	input  wire							dram_valid,
	input  wire							dram_ready,
	input  wire dram_if_pkg::dram_rsp_t	dram_rsp,
	input  wire dram_if_pkg::dram_req_t	store_req		// Request in flight
);

	int		failures = 0;	// Watched by the testbench top
	logic	cpu_rd;

	assign cpu_rd = bus.ioreq && bus.valid && !bus.write;

	// ------------------------------
	// CPU bus
	// ------------------------------
	a_read_returns: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_rd |=> bus_rdata_en)
		else begin failures++; $error("bus_rdata_en missing after a CPU read"); end

	a_read_only: assert property (@(posedge clk) disable iff (!reset_n)
		bus_rdata_en |-> $past(cpu_rd))
		else begin failures++; $error("bus_rdata_en without a CPU read"); end

	a_rdata_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		!bus_rdata_en |-> (bus_rdata == 8'h00))
		else begin
			failures++;
			$error("[FAIL] bus_rdata got %h expected 00 while bus_rdata_en is low",
				$sampled(bus_rdata));
		end

	// ------------------------------
	// DRAM handshake
	// ------------------------------
	a_valid_holds: assert property (@(posedge clk) disable iff (!reset_n)
		(dram_valid && !dram_ready) |=> dram_valid)
		else begin failures++; $error("dram_valid dropped before acceptance"); end

	a_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
		(dram_valid && !dram_ready) |=> $stable(dram_req))
		else begin failures++; $error("dram_req changed before acceptance"); end

	// Read data only ever answers a read
	a_rsp_for_read: assert property (@(posedge clk) disable iff (!reset_n)
		dram_rsp.rdata_en |-> !store_req.write)
		else begin failures++; $error("dram_rsp.rdata_en for a write request"); end

endmodule

bind ddr3_test_top ddr3_test_checks u_checks (
	.clk				(clk),
	.reset_n			(reset_n),
	.bus				(bus),
	.bus_rdata			(bus_rdata),
	.bus_rdata_en		(bus_rdata_en),
	.dram_req			(dram_req),
	.dram_valid			(dram_valid),
	.dram_ready			(dram_ready),
	.dram_rsp			(dram_rsp),
	.store_req			(store_req)
);

`default_nettype wire

/* tb_ddr3_test.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr3_test;

	localparam int TIMEOUT_CYCLES = 4000;	// About twice the test length

	logic					clk;
	logic					reset_n;
	cpu_io_pkg::cpu_bus_t	bus;
	wire [7:0]				bus_rdata;
	wire					bus_rdata_en;
	wire					sdram_init_busy;

	integer					seed;
	int						cycle_count = 0;
	logic [127:0]			ref_mem [16];		// Reference store by column bits 3..0
	logic [13:0]			ref_open_row [8];
	logic [7:0]				ref_row_valid;
	logic [26:0]			test_addr [4];
	logic [7:0]				delay_hit;
	logic [7:0]				delay_miss;
	logic [7:0]				delay_unused;

	ddr3_test_top DUT (
		.clk				(clk),
		.reset_n			(reset_n),
		.bus				(bus),
		.bus_rdata			(bus_rdata),
		.bus_rdata_en		(bus_rdata_en),
		.sdram_init_busy	(sdram_init_busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	// ------------------------------
	// Failure handling and timeout
	// ------------------------------
	task automatic stop_with_failure();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_word(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	// Protocol assertions raise the count
	always @(negedge clk) begin
		if (DUT.u_checks.failures != 0) begin
			$display("A bus protocol assertion failed");
			stop_with_failure();
		end
	end

	// ------------------------------
	// Bus access tasks
	// ------------------------------
	task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		bus <= '{ioreq: 1'b1, valid: 1'b1, write: 1'b1, address: addr, wdata: data};
		@(posedge clk);
		bus <= '0;
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
		@(posedge clk);
		bus <= '{ioreq: 1'b1, valid: 1'b1, write: 1'b0, address: addr, wdata: 8'h00};
		@(posedge clk);
		bus <= '0;
		@(negedge clk);
		data = bus_rdata;	// Valid one cycle after the access
	endtask

	task automatic load_address(input logic [26:0] addr);
		bus_write(cpu_io_pkg::REG_ADDR0, addr[7:0]);
		bus_write(cpu_io_pkg::REG_ADDR1, addr[15:8]);
		bus_write(cpu_io_pkg::REG_ADDR2, addr[23:16]);
		bus_write(cpu_io_pkg::REG_ADDR3, {5'd0, addr[26:24]});	// Bank
	endtask

	// Data, mask and address of the next request
	task automatic load_request(input logic [26:0] addr, input logic [127:0] data,
			input logic [15:0] mask);
		for (int i = 0; i < 16; i++) begin
			bus_write(8'(cpu_io_pkg::REG_DATA_BASE + i), data[i*8 +: 8]);
		end
		bus_write(cpu_io_pkg::REG_MASK_LO, mask[7:0]);
		bus_write(cpu_io_pkg::REG_MASK_HI, mask[15:8]);
		load_address(addr);
	endtask

	// Busy seen, then ready back
	task automatic wait_access_done();
		logic [7:0] value;
		value = 8'h00;
		while (value == 8'h00) bus_read(cpu_io_pkg::REG_BUSY_COUNT, value);
		value = 8'h01;
		while (value[0]) bus_read(cpu_io_pkg::REG_STATUS, value);
	endtask

	// Open row model where a miss opens the row
	task automatic predict_latency(input logic [26:0] addr, output int lat);
		logic [2:0]		bank;
		logic [13:0]	row;
		bank = addr[dram_if_pkg::BANK_LSB +: dram_if_pkg::BANK_W];
		row  = addr[dram_if_pkg::ROW_LSB +: dram_if_pkg::ROW_W];
		if (ref_row_valid[bank] && (ref_open_row[bank] == row)) begin
			lat = dram_if_pkg::ROW_HIT_CYCLES;
		end else begin
			lat = dram_if_pkg::ROW_MISS_CYCLES;
		end
		ref_row_valid[bank]	= 1'b1;
		ref_open_row[bank]	= row;
	endtask

	// All 16 captured bytes against the reference word
	task automatic check_stored_word(input string name, input logic [26:0] addr);
		logic [7:0]		value;
		logic [127:0]	word;
		for (int i = 0; i < 16; i++) begin
			bus_read(8'(cpu_io_pkg::REG_DATA_BASE + i), value);
			word[i*8 +: 8] = value;
		end
		check_word(name, word, ref_mem[addr[3:0]]);
	endtask

	// ------------------------------
	// Word level accesses
	// ------------------------------
	task automatic write_word(input logic [26:0] addr, input logic [127:0] data,
			input logic [15:0] mask);
		int			lat;
		logic [7:0]	busy;
		load_request(addr, data, mask);
		bus_write(cpu_io_pkg::REG_CMD_WRITE, 8'h00);
		predict_latency(addr, lat);
		wait_access_done();
		bus_read(cpu_io_pkg::REG_BUSY_COUNT, busy);
		check_byte("busy_count after write", busy, 8'(lat));
		for (int i = 0; i < 16; i++) begin
			if (!mask[i]) ref_mem[addr[3:0]][i*8 +: 8] = data[i*8 +: 8];	// DM low writes
		end
	endtask

	task automatic read_word(input logic [26:0] addr, output logic [7:0] delay);
		int				lat;
		logic [7:0]		value;
		load_address(addr);
		bus_write(cpu_io_pkg::REG_CMD_READ, 8'h00);
		predict_latency(addr, lat);
		wait_access_done();
		value = 8'h00;
		while (!value[0]) bus_read(cpu_io_pkg::REG_DELAY_END, value);	// Read data landed
		bus_read(cpu_io_pkg::REG_DELAY_COUNT, delay);
		bus_read(cpu_io_pkg::REG_BUSY_COUNT, value);
		check_byte("busy_count after read", value, 8'(lat));
		check_stored_word("read word", addr);
	endtask

	// Read fired while the write still holds ready low
	task automatic write_then_read(input logic [26:0] addr, input logic [127:0] data);
		logic [7:0] value;
		load_request(addr, data, 16'h0000);
		bus_write(cpu_io_pkg::REG_CMD_WRITE, 8'h00);
		bus_write(cpu_io_pkg::REG_CMD_READ, 8'h00);
		ref_mem[addr[3:0]] = data;
		value = 8'h00;
		while (!value[0]) bus_read(cpu_io_pkg::REG_DELAY_END, value);
		check_stored_word("read word behind a busy write", addr);
	endtask

	task automatic check_init();
		logic [7:0]	status;
		int			init_start;
		@(negedge clk);
		init_start = cycle_count;	// First cycle out of reset
		bus_read(cpu_io_pkg::REG_STATUS, status);
		check_byte("status during init", status & 8'h81, 8'h81);	// Busy and not ready
		while (sdram_init_busy) @(negedge clk);
		check_byte("sdram_init_busy cycles", 8'(cycle_count - init_start),
			8'(dram_if_pkg::INIT_CYCLES));
		bus_read(cpu_io_pkg::REG_STATUS, status);
		check_byte("status after init", status, 8'h00);
	endtask

	function automatic logic [127:0] random_word();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		bus				= '0;
		reset_n			= 1'b0;
		seed			= 32'ha321_baae;
		ref_row_valid	= 8'h00;
		test_addr[0]	= {3'd0, 14'h0123, 10'd0};
		test_addr[1]	= {3'd0, 14'h0123, 10'd1};	// Same row as entry 0
		test_addr[2]	= {3'd1, 14'h2000, 10'd2};
		test_addr[3]	= {3'd0, 14'h0456, 10'd3};	// Moves bank 0 to a new row
		repeat (4) @(posedge clk);
		reset_n <= 1'b1;

		check_init();

		for (int i = 0; i < 4; i++) begin
			write_word(test_addr[i], random_word(), 16'h0000);	// Fill whole words
		end
		repeat (2) begin
			for (int i = 0; i < 4; i++) begin
				write_word(test_addr[i], random_word(), 16'($random(seed)));
			end
			for (int i = 0; i < 4; i++) begin
				read_word(test_addr[i], delay_unused);
			end
		end

		// Hit then miss on bank 2 in the same column
		write_word({3'd2, 14'h0007, 10'd5}, random_word(), 16'h0000);
		read_word({3'd2, 14'h0007, 10'd5}, delay_hit);
		read_word({3'd2, 14'h0009, 10'd5}, delay_miss);
		check_byte("delay_count difference", delay_miss - delay_hit,
			8'(dram_if_pkg::ROW_MISS_CYCLES - dram_if_pkg::ROW_HIT_CYCLES));

		// Valid waits on ready
		write_then_read({3'd3, 14'h0011, 10'd6}, random_word());

		@(negedge clk);
		if (DUT.u_checks.failures == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("A bus protocol assertion failed at the end of the run");
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

/* ddr3_test.f */
cpu_io_pkg.sv
dram_if_pkg.sv
test_controller.sv
dram_timing_model.sv
dram_storage.sv
ddr3_test_top.sv
tb_ddr3_test_assert.sv
tb_ddr3_test.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ddr3_test -f ddr3_test.f -o sim_ddr3_test

# Keep going after an assertion so the testbench reports the failure
./obj_dir/sim_ddr3_test +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
